/* flist.f */
+incdir+src
src/thr_pkg.sv
src/thr_fifo.sv
src/thr_compare.sv
src/thr_ctrl.sv
src/thr_top.sv
sim/thr_assert.sv
sim/thr_check.sv
sim/thr_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the thresholding testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module thr_tb -f flist.f --Mdir "$BUILD_DIR" -o thr_tb_sim; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/thr_tb_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Simulation PASSED" "$LOG"; then
  exit 0
fi
echo "pass line not found in $LOG"
exit 1

/* sim/thr_assert.sv */
////////////////////
// Concurrent checks on the output stream and both FIFOs
// Bound into every thr_top instance
// Rules are suspended while reset is low
////////////////////

module thr_assert (
  input logic        i_ce_clk,
  input logic        i_rst_n,
  input logic [31:0] i_out_data,
  input logic        i_out_last,
  input logic        i_out_valid,
  input logic        i_out_ready,
  input logic        i_smp_push,
  input logic        i_smp_full,
  input logic        i_smp_pop,
  input logic        i_smp_empty,
  input logic        i_len_push,
  input logic        i_len_full,
  input logic        i_len_pop,
  input logic        i_len_empty
);

  // Failed checks so far
  int fail_count = 0;

  // Framer holds its word while stalled
  stall_hold: assert property (
    @(posedge i_ce_clk) disable iff (!i_rst_n)
    i_out_valid && !i_out_ready |=> i_out_valid && $stable(i_out_data) && $stable(i_out_last)
  ) else begin
    $error("output word changed while stalled");
    fail_count++;
  end

  ////////////////////
  // FIFO rules
  ////////////////////
  smp_no_overflow: assert property (
    @(posedge i_ce_clk) disable iff (!i_rst_n) !(i_smp_push && i_smp_full)
  ) else begin
    $error("push into full payload FIFO");
    fail_count++;
  end

  len_no_overflow: assert property (
    @(posedge i_ce_clk) disable iff (!i_rst_n) !(i_len_push && i_len_full)
  ) else begin
    $error("push into full length FIFO");
    fail_count++;
  end

  smp_no_underflow: assert property (
    @(posedge i_ce_clk) disable iff (!i_rst_n) !(i_smp_pop && i_smp_empty)
  ) else begin
    $error("pop from empty payload FIFO");
    fail_count++;
  end

  len_no_underflow: assert property (
    @(posedge i_ce_clk) disable iff (!i_rst_n) !(i_len_pop && i_len_empty)
  ) else begin
    $error("pop from empty length FIFO");
    fail_count++;
  end

endmodule

bind thr_top thr_assert u_assert (
  .i_ce_clk    (i_ce_clk),
  .i_rst_n     (i_rst_n),
  .i_out_data  (o_tdata),
  .i_out_last  (o_tlast),
  .i_out_valid (o_tvalid),
  .i_out_ready (i_tready),
  .i_smp_push  (smp_push),
  .i_smp_full  (smp_full),
  .i_smp_pop   (smp_pop),
  .i_smp_empty (smp_empty),
  .i_len_push  (len_push),
  .i_len_full  (len_full),
  .i_len_pop   (len_pop),
  .i_len_empty (len_empty)
);

/* sim/thr_check.sv */
////////////////////
// Reference model and scoreboard for the thresholding block
// Expects ID writes and i_clear only while the block is idle
// Readback is compared only on i_rb_check, after traffic has drained
////////////////////

`include "thr_macros.svh"

module thr_check
  import thr_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_clear,
  input  logic                   i_set_stb,
  input  logic [`THR_SET_AW-1:0] i_set_addr,
  input  logic [`THR_SET_DW-1:0] i_set_data,
  input  logic                   i_rb_check,
  input  logic [`THR_RB_AW-1:0]  i_rb_addr,
  input  logic [`THR_RB_DW-1:0]  i_rb_data,
  input  logic                   i_end_check,
  input  sample_t                i_in_data,
  input  logic                   i_in_last,
  input  logic                   i_in_valid,
  input  logic                   i_in_ready,
  input  sample_t                i_out_data,
  input  logic                   i_out_last,
  input  logic                   i_out_valid,
  input  logic                   i_out_ready,
  output int                     o_errors,
  output int                     o_pending,
  output seqnum_t                o_seq
);

  sample_t     thr;
  sid_t        src_id;
  sid_t        dst_id;
  logic [31:0] kept_total;
  seqnum_t     seq;
  sample_t     cur_kept[$];
  sample_t     exp_words[$];
  pkt_len_t    exp_lens[$];
  int          remain;
  logic        stray;
  logic        first_cycle;
  int          errors = 0;
  int          pending;
  logic [63:0] rb_exp;
  sample_t     exp_hdr;
  sample_t     exp_word;
  pkt_len_t    len;

  assign o_errors  = errors;
  assign o_pending = pending;
  assign o_seq     = seq;

  function automatic logic [63:0] expected_readback(input logic [7:0] addr);
    case (addr)
      `THR_RB_THRESHOLD:   return {32'd0, thr};
      `THR_RB_NUM_SAMPLES: return {32'd0, kept_total};
      `THR_RB_SID:         return {48'd0, dst_id, src_id};
      default:             return `THR_RB_DEFAULT;
    endcase
  endfunction

  ////////////////////
  // Output side
  ////////////////////
  task compare_output();
    if (remain == 0) begin
      if (exp_lens.size() == 0) begin
        $display("unexpected output packet at time %0t, header %h", $time, i_out_data);
        errors++;
        stray  = 1'b1;
        remain = int'(i_out_data[11:0]);
      end else begin
        len     = exp_lens.pop_front();
        exp_hdr = {dst_id, src_id, seq, len};
        stray   = 1'b0;
        remain  = int'(len);
        if (i_out_data !== exp_hdr || i_out_last !== 1'b0) begin
          $display("[ERROR] %0t: header %h last %b, expected %h last 0",
                   $time, i_out_data, i_out_last, exp_hdr);
          errors++;
        end
      end
    end else begin
      if (!stray) begin
        exp_word = exp_words.pop_front();
        if (i_out_data !== exp_word || i_out_last !== (remain == 1)) begin
          $display("[ERROR] %0t: payload %h last %b, expected %h last %b",
                   $time, i_out_data, i_out_last, exp_word, remain == 1);
          errors++;
        end
      end
      remain--;
      if (remain == 0) begin
        seq = seq + 1'b1;
        if (!stray) pending--;
      end
    end
  endtask

  always @(posedge i_clk) begin
    if (!i_rst_n) begin
      thr         = '0;
      src_id      = '0;
      dst_id      = '0;
      kept_total  = '0;
      seq         = '0;
      remain      = 0;
      stray       = 1'b0;
      pending     = 0;
      first_cycle = 1'b1;
      cur_kept.delete();
      exp_words.delete();
      exp_lens.delete();
    end else begin
      // Input ready comes up on the first cycle out of reset
      if (first_cycle && i_in_ready !== 1'b1) begin
        $display("[ERROR] %0t: input ready low on the first cycle after reset", $time);
        errors++;
      end
      first_cycle = 1'b0;
      // Kept list of the open input packet
      if (i_in_valid && i_in_ready) begin
        if (i_in_data > thr) begin
          cur_kept.push_back(i_in_data);
          kept_total = kept_total + 1;
        end
        if (i_in_last) begin
          if (cur_kept.size() > 0) begin
            exp_lens.push_back(pkt_len_t'(cur_kept.size()));
            foreach (cur_kept[k]) exp_words.push_back(cur_kept[k]);
            pending++;
          end
          cur_kept.delete();
        end
      end
      if (i_out_valid && i_out_ready) begin
        compare_output();
      end
      if (i_rb_check) begin
        rb_exp = expected_readback(i_rb_addr);
        if (i_rb_data !== rb_exp) begin
          $display("[ERROR] %0t: readback addr %0d got %h, expected %h",
                   $time, i_rb_addr, i_rb_data, rb_exp);
          errors++;
        end
      end
      if (i_end_check && pending != 0) begin
        $display("%0d expected output packets never arrived", pending);
        errors++;
      end
      if (i_clear) begin
        kept_total = '0;
        seq        = '0;
      end
      // New settings apply from the next cycle
      if (i_set_stb && i_set_addr == `THR_SR_THRESHOLD) thr = i_set_data;
      if (i_set_stb && i_set_addr == `THR_SR_SID) begin
        src_id = i_set_data[7:0];
        dst_id = i_set_data[15:8];
      end
    end
  end

endmodule

/* sim/thr_tb.sv */
////////////////////
// Testbench for thr_top with random packets from a fixed xorshift seed
// Inputs change on the falling edge and the checker samples on the rising edge
// Run length is bounded by a watchdog sized from the packet counts
////////////////////

`include "thr_macros.svh"

module thr_tb
  import thr_pkg::*;
();

  localparam logic [31:0] SEED = 32'hcc9b_c226;
  localparam int N_RANDOM    = 24;
  localparam int N_LOW       = 6;
  localparam int N_STALL     = 40;
  localparam int MAX_SAMPLES = (N_RANDOM + N_LOW + N_STALL + 2) * 32;
  localparam int WATCHDOG_CYCLES = MAX_SAMPLES * 20;
  localparam int DRAIN_LIMIT = 4000;
  localparam int NUM_TESTS   = 5;

  logic                   clk;
  logic                   rst_n;
  logic                   clear;
  logic                   set_stb;
  logic [`THR_SET_AW-1:0] set_addr;
  logic [`THR_SET_DW-1:0] set_data;
  logic [`THR_RB_AW-1:0]  rb_addr;
  logic [`THR_RB_DW-1:0]  rb_data;
  logic                   rb_check;
  logic                   end_check;
  sample_t                tdata;
  logic                   tlast;
  logic                   tvalid;
  logic                   in_ready;
  sample_t                out_data;
  logic                   out_last;
  logic                   out_valid;
  logic                   tready;
  logic                   stall_en;
  logic [31:0]            rng;
  logic [31:0]            stall_rng;
  sample_t                cur_thr;
  int                     err_count;
  int                     pending;
  seqnum_t                model_seq;
  int                     tb_errors;
  int                     failed;
  int                     test_err0;

  thr_top dut (
    .i_ce_clk   (clk),
    .i_rst_n    (rst_n),
    .i_clear    (clear),
    .i_set_stb  (set_stb),
    .i_set_addr (set_addr),
    .i_set_data (set_data),
    .i_rb_addr  (rb_addr),
    .o_rb_data  (rb_data),
    .i_tdata    (tdata),
    .i_tlast    (tlast),
    .i_tvalid   (tvalid),
    .o_tready   (in_ready),
    .o_tdata    (out_data),
    .o_tlast    (out_last),
    .o_tvalid   (out_valid),
    .i_tready   (tready)
  );

  thr_check u_check (
    .i_clk       (clk),
    .i_rst_n     (rst_n),
    .i_clear     (clear),
    .i_set_stb   (set_stb),
    .i_set_addr  (set_addr),
    .i_set_data  (set_data),
    .i_rb_check  (rb_check),
    .i_rb_addr   (rb_addr),
    .i_rb_data   (rb_data),
    .i_end_check (end_check),
    .i_in_data   (tdata),
    .i_in_last   (tlast),
    .i_in_valid  (tvalid),
    .i_in_ready  (in_ready),
    .i_out_data  (out_data),
    .i_out_last  (out_last),
    .i_out_valid (out_valid),
    .i_out_ready (tready),
    .o_errors    (err_count),
    .o_pending   (pending),
    .o_seq       (model_seq)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Scoreboard, testbench and assertion failures together
  function automatic int error_total();
    return err_count + tb_errors + dut.u_assert.fail_count;
  endfunction

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Random back-pressure from its own random stream
  always @(negedge clk) begin
    stall_rng = xorshift(stall_rng);
    if (stall_en) begin
      tready = (stall_rng[1:0] != 2'b00);
    end else begin
      tready = 1'b1;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

  task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
    @(negedge clk);
    set_stb  = 1'b1;
    set_addr = addr;
    set_data = data;
    @(negedge clk);
    set_stb  = 1'b0;
  endtask

  task automatic request_readback(input logic [7:0] addr);
    @(negedge clk);
    rb_addr  = addr;
    rb_check = 1'b1;
    @(negedge clk);
    rb_check = 1'b0;
  endtask

  // Mode 0 gives random values, 1 values at or below threshold and 2 values above it
  task automatic send_packet(input int len, input int mode);
    sample_t val;
    for (int i = 0; i < len; i++) begin
      rng = xorshift(rng);
      case (mode)
        0:       val = sample_t'(rng);
        1:       val = (i == 0) ? cur_thr : cur_thr - sample_t'(rng[7:0]);
        default: val = cur_thr + 1 + sample_t'(rng[7:0]);
      endcase
      @(negedge clk);
      tvalid = 1'b1;
      tdata  = val;
      tlast  = (i == len - 1);
      do begin
        @(posedge clk);
      end while (!in_ready);
    end
    @(negedge clk);
    tvalid = 1'b0;
    tlast  = 1'b0;
  endtask

  task automatic new_threshold();
    rng     = xorshift(rng);
    cur_thr = sample_t'(rng) >>> 1;
    write_setting(`THR_SR_THRESHOLD, cur_thr);
  endtask

  // Waits until every expected packet has left the DUT
  task automatic wait_drain();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while ((pending != 0 || out_valid) && n < DRAIN_LIMIT);
    if (pending != 0 || out_valid) begin
      $display("output did not drain within %0d cycles", DRAIN_LIMIT);
      tb_errors++;
    end
    repeat (8) @(negedge clk);
  endtask

  task automatic report_test(input int num, input string name);
    if (error_total() == test_err0) begin
      $display("test %0d %s: pass", num, name);
    end else begin
      failed++;
      $display("test %0d %s: fail, %0d errors", num, name, error_total() - test_err0);
    end
    test_err0 = error_total();
  endtask

  initial begin
    rst_n     = 1'b0;
    clear     = 1'b0;
    set_stb   = 1'b0;
    set_addr  = '0;
    set_data  = '0;
    rb_addr   = '0;
    rb_check  = 1'b0;
    end_check = 1'b0;
    tdata     = '0;
    tlast     = 1'b0;
    tvalid    = 1'b0;
    tready    = 1'b1;
    stall_en  = 1'b0;
    rng       = SEED;
    stall_rng = xorshift(SEED);
    cur_thr   = '0;
    tb_errors = 0;
    failed    = 0;
    test_err0 = 0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Readback defaults and values after writes
    request_readback(`THR_RB_THRESHOLD);
    request_readback(`THR_RB_NUM_SAMPLES);
    request_readback(`THR_RB_SID);
    request_readback(8'd5);
    cur_thr = 32'h1234_5678;
    write_setting(`THR_SR_THRESHOLD, cur_thr);
    write_setting(`THR_SR_SID, 32'hffff_a55a);
    request_readback(`THR_RB_THRESHOLD);
    request_readback(`THR_RB_SID);
    request_readback(8'd200);
    report_test(1, "readback");

    for (int p = 0; p < N_RANDOM; p++) begin
      new_threshold();
      rng = xorshift(rng);
      send_packet(1 + int'(rng[4:0]), 0);
    end
    wait_drain();
    request_readback(`THR_RB_NUM_SAMPLES);
    report_test(2, "random packets");

    for (int p = 0; p < N_LOW; p++) begin
      new_threshold();
      rng = xorshift(rng);
      send_packet(1 + int'(rng[4:0]), 1);
    end
    wait_drain();
    report_test(3, "packets with nothing kept");

    @(posedge clk);
    stall_en = 1'b1;
    for (int p = 0; p < N_STALL; p++) begin
      new_threshold();
      rng = xorshift(rng);
      send_packet(1 + int'(rng[4:0]), 0);
    end
    @(posedge clk);
    stall_en = 1'b0;
    wait_drain();
    report_test(4, "back-pressure and sequence wrap");

    // The clear needs a nonzero sequence number to undo
    if (model_seq == '0) begin
      new_threshold();
      send_packet(1, 2);
      wait_drain();
    end
    @(negedge clk);
    clear = 1'b1;
    @(negedge clk);
    clear = 1'b0;
    request_readback(`THR_RB_NUM_SAMPLES);
    new_threshold();
    send_packet(4, 2);
    wait_drain();
    request_readback(`THR_RB_NUM_SAMPLES);
    report_test(5, "clear");

    @(negedge clk);
    end_check = 1'b1;
    @(negedge clk);
    end_check = 1'b0;
    $display("tests run %0d, failed %0d, errors %0d", NUM_TESTS, failed, error_total());
    if (error_total() == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* src/thr_compare.sv */
////////////////////
// Compare stage, one register between the input stream and the FIFOs
// A packet that keeps no sample pushes no length
// Input ready needs room in both FIFOs
////////////////////

module thr_compare
  import thr_pkg::*;
(
  input  logic     i_ce_clk,
  input  logic     i_rst_n,
  input  sample_t  i_threshold,
  // Input stream
  input  sample_t  i_tdata,
  input  logic     i_tlast,
  input  logic     i_tvalid,
  output logic     o_tready,
  // Payload FIFO write side
  output sample_t  o_smp_data,
  output logic     o_smp_push,
  input  logic     i_smp_full,
  // Length FIFO write side
  output pkt_len_t o_len_data,
  output logic     o_len_push,
  input  logic     i_len_full,
  output logic     o_kept_stb
);

  logic     r_valid;
  sample_t  r_data;
  logic     r_keep;
  logic     r_last;
  pkt_len_t r_cnt;
  pkt_len_t cnt_next;
  logic     room;
  logic     drain;
  logic     accept;

  assign room     = !i_smp_full && !i_len_full;
  assign drain    = r_valid && room;
  assign o_tready = (!r_valid || drain) && room;
  assign accept   = i_tvalid && o_tready;

  ////////////////////
  // Register stage
  ////////////////////
  always_ff @(posedge i_ce_clk) begin
    if (!i_rst_n) begin
      r_valid <= 1'b0;
    end else if (accept) begin
      r_valid <= 1'b1;
    end else if (drain) begin
      r_valid <= 1'b0;
    end
  end

  // Signed greater-than against the current threshold
  always_ff @(posedge i_ce_clk) begin
    if (accept) begin
      r_data <= i_tdata;
      r_keep <= i_tdata > i_threshold;
      r_last <= i_tlast;
    end
  end

  ////////////////////
  // Per-packet kept count
  ////////////////////
  assign cnt_next = r_cnt + pkt_len_t'(r_keep);

  always_ff @(posedge i_ce_clk) begin
    if (!i_rst_n) begin
      r_cnt <= '0;
    end else if (drain) begin
      // Restart on each packet boundary
      r_cnt <= r_last ? '0 : cnt_next;
    end
  end

  assign o_smp_data = r_data;
  assign o_smp_push = drain && r_keep;
  assign o_len_data = cnt_next;
  assign o_len_push = drain && r_last && (cnt_next != '0);
  assign o_kept_stb = o_smp_push;

endmodule

/* src/thr_ctrl.sv */
////////////////////
// Settings, readback and output framing
// Header is dst ID, src ID, sequence number, length, high bits first
// A length is popped only once its whole payload sits in the FIFO
////////////////////

`include "thr_macros.svh"

module thr_ctrl
  import thr_pkg::*;
(
  input  logic                   i_ce_clk,
  input  logic                   i_rst_n,
  input  logic                   i_clear,
  // Settings bus
  input  logic                   i_set_stb,
  input  logic [`THR_SET_AW-1:0] i_set_addr,
  input  logic [`THR_SET_DW-1:0] i_set_data,
  // Readback
  input  logic [`THR_RB_AW-1:0]  i_rb_addr,
  output logic [`THR_RB_DW-1:0]  o_rb_data,
  output sample_t                o_threshold,
  input  logic                   i_kept_stb,
  // Length FIFO read side
  input  pkt_len_t               i_len_data,
  input  logic                   i_len_empty,
  output logic                   o_len_pop,
  // Payload FIFO read side
  input  sample_t                i_smp_data,
  output logic                   o_smp_pop,
  // Output stream
  output sample_t                o_tdata,
  output logic                   o_tlast,
  output logic                   o_tvalid,
  input  logic                   i_tready
);

  sample_t      threshold;
  sid_t         src_sid;
  sid_t         dst_sid;
  logic [31:0]  kept_cnt;
  seqnum_t      seqnum;
  frame_state_t state;
  pkt_len_t     remain;
  logic         last_beat;

  ////////////////////
  // Settings registers
  ////////////////////
  always_ff @(posedge i_ce_clk) begin
    if (!i_rst_n) begin
      threshold <= '0;
      src_sid   <= '0;
      dst_sid   <= '0;
    end else if (i_set_stb) begin
      if (i_set_addr == `THR_SR_THRESHOLD) begin
        threshold <= i_set_data;
      end
      if (i_set_addr == `THR_SR_SID) begin
        src_sid <= i_set_data[7:0];
        dst_sid <= i_set_data[15:8];
      end
    end
  end

  assign o_threshold = threshold;

  // Running total of kept samples, clear wins
  always_ff @(posedge i_ce_clk) begin
    if (!i_rst_n || i_clear) begin
      kept_cnt <= '0;
    end else if (i_kept_stb) begin
      kept_cnt <= kept_cnt + 1'b1;
    end
  end

  always_comb begin
    case (i_rb_addr)
      `THR_RB_THRESHOLD:   o_rb_data = {32'd0, threshold};
      `THR_RB_NUM_SAMPLES: o_rb_data = {32'd0, kept_cnt};
      `THR_RB_SID:         o_rb_data = {48'd0, dst_sid, src_sid};
      default:             o_rb_data = `THR_RB_DEFAULT;
    endcase
  end

  ////////////////////
  // Framer
  ////////////////////
  assign last_beat = (state == FR_PAYLOAD) && (remain == pkt_len_t'(1)) && i_tready;

  always_ff @(posedge i_ce_clk) begin
    if (!i_rst_n) begin
      state <= FR_IDLE;
    end else begin
      case (state)
        FR_IDLE:    if (!i_len_empty) state <= FR_HEADER;
        FR_HEADER:  if (i_tready) state <= FR_PAYLOAD;
        FR_PAYLOAD: if (last_beat) state <= FR_IDLE;
        default:    state <= FR_IDLE;
      endcase
    end
  end

  // Length for the header, then counts down the payload
  always_ff @(posedge i_ce_clk) begin
    if (state == FR_IDLE) begin
      remain <= i_len_data;
    end else if (state == FR_PAYLOAD && i_tready) begin
      remain <= remain - 1'b1;
    end
  end

  always_ff @(posedge i_ce_clk) begin
    if (!i_rst_n || i_clear) begin
      seqnum <= '0;
    end else if (last_beat) begin
      seqnum <= seqnum + 1'b1;
    end
  end

  assign o_tvalid  = (state != FR_IDLE);
  assign o_tdata   = (state == FR_HEADER) ? {dst_sid, src_sid, seqnum, remain} : i_smp_data;
  assign o_tlast   = (state == FR_PAYLOAD) && (remain == pkt_len_t'(1));
  assign o_len_pop = (state == FR_HEADER) && i_tready;
  assign o_smp_pop = (state == FR_PAYLOAD) && i_tready;

endmodule

/* src/thr_fifo.sv */
////////////////////
// Synchronous FIFO, first word falls through to the read port
// DEPTH must be a power of two
// Writes when full and reads when empty are ignored
////////////////////

module thr_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 64
) (
  input  logic             i_ce_clk,
  input  logic             i_rst_n,
  input  logic [WIDTH-1:0] i_wr_data,
  input  logic             i_wr_en,
  output logic             o_full,
  output logic [WIDTH-1:0] o_rd_data,
  input  logic             i_rd_en,
  output logic             o_empty
);

  localparam int AW = $clog2(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [AW:0]      count;
  logic             wr;
  logic             rd;

  assign o_full  = (count == (AW+1)'(DEPTH));
  assign o_empty = (count == '0);
  assign wr      = i_wr_en && !o_full;
  assign rd      = i_rd_en && !o_empty;

  // Head word is always on the read port
  assign o_rd_data = mem[rd_ptr];

  always_ff @(posedge i_ce_clk) begin
    if (wr) begin
      mem[wr_ptr] <= i_wr_data;
    end
  end

  // Pointers wrap naturally at DEPTH
  always_ff @(posedge i_ce_clk) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr) wr_ptr <= wr_ptr + 1'b1;
      if (rd) rd_ptr <= rd_ptr + 1'b1;
      if (wr && !rd) begin
        count <= count + 1'b1;
      end else if (rd && !wr) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

/* src/thr_macros.svh */
////////////////////
// Register map, FIFO depths and field widths of the thresholding block
// FIFO depths must be powers of two
// Input packets longer than THR_MAX_PKT samples are not supported
////////////////////

`ifndef THR_MACROS_SVH
`define THR_MACROS_SVH

// Settings bus addresses
`define THR_SR_THRESHOLD   8'd128
`define THR_SR_SID         8'd130

// Readback addresses
`define THR_RB_THRESHOLD   8'd0
`define THR_RB_NUM_SAMPLES 8'd1
`define THR_RB_SID         8'd2
`define THR_RB_DEFAULT     64'h0BAD_C0DE_0BAD_C0DE

// Buffering
`define THR_PAYLOAD_DEPTH  64
`define THR_LEN_DEPTH      8
`define THR_MAX_PKT        64

// Field widths
`define THR_SAMPLE_W       32
`define THR_LEN_W          12
`define THR_SID_W          8
`define THR_SEQ_W          4
`define THR_SET_AW         8
`define THR_SET_DW         32
`define THR_RB_AW          8
`define THR_RB_DW          64

`endif

/* src/thr_pkg.sv */
////////////////////
// Types for the thresholding block
// Widths come from the field macros, so both must stay in step
// Samples are two's complement and compared signed
////////////////////

`include "thr_macros.svh"

package thr_pkg;

  // One stream word, also used for the header word
  typedef logic signed [`THR_SAMPLE_W-1:0] sample_t;

  // Kept samples in one packet, as carried in the header
  typedef logic [`THR_LEN_W-1:0] pkt_len_t;

  // Stream ID, one byte each for source and destination
  typedef logic [`THR_SID_W-1:0] sid_t;

  // Wraps modulo 16
  typedef logic [`THR_SEQ_W-1:0] seqnum_t;

  // Output framer
  typedef enum logic [1:0] {
    FR_IDLE,
    FR_HEADER,
    FR_PAYLOAD
  } frame_state_t;

endpackage

/* src/thr_top.sv */
////////////////////
// Thresholding block, single clock domain
// Kept samples of each input packet leave as one packet behind a header word
// Input packets must not exceed THR_MAX_PKT samples
////////////////////

`include "thr_macros.svh"

module thr_top
  import thr_pkg::*;
(
  input  logic                   i_ce_clk,
  input  logic                   i_rst_n,
  input  logic                   i_clear,
  // Settings and readback
  input  logic                   i_set_stb,
  input  logic [`THR_SET_AW-1:0] i_set_addr,
  input  logic [`THR_SET_DW-1:0] i_set_data,
  input  logic [`THR_RB_AW-1:0]  i_rb_addr,
  output logic [`THR_RB_DW-1:0]  o_rb_data,
  // Sample stream in
  input  sample_t                i_tdata,
  input  logic                   i_tlast,
  input  logic                   i_tvalid,
  output logic                   o_tready,
  // Packet stream out
  output sample_t                o_tdata,
  output logic                   o_tlast,
  output logic                   o_tvalid,
  input  logic                   i_tready
);

  sample_t  threshold;
  sample_t  smp_wr_data;
  sample_t  smp_rd_data;
  logic     smp_push;
  logic     smp_pop;
  logic     smp_full;
  logic     smp_empty;
  pkt_len_t len_wr_data;
  pkt_len_t len_rd_data;
  logic     len_push;
  logic     len_pop;
  logic     len_full;
  logic     len_empty;
  logic     kept_stb;

  thr_compare u_compare (
    .i_ce_clk    (i_ce_clk),
    .i_rst_n     (i_rst_n),
    .i_threshold (threshold),
    .i_tdata     (i_tdata),
    .i_tlast     (i_tlast),
    .i_tvalid    (i_tvalid),
    .o_tready    (o_tready),
    .o_smp_data  (smp_wr_data),
    .o_smp_push  (smp_push),
    .i_smp_full  (smp_full),
    .o_len_data  (len_wr_data),
    .o_len_push  (len_push),
    .i_len_full  (len_full),
    .o_kept_stb  (kept_stb)
  );

  // Kept samples, whole packets wait here for their header
  thr_fifo #(
    .WIDTH (`THR_SAMPLE_W),
    .DEPTH (`THR_PAYLOAD_DEPTH)
  ) u_payload_fifo (
    .i_ce_clk  (i_ce_clk),
    .i_rst_n   (i_rst_n),
    .i_wr_data (smp_wr_data),
    .i_wr_en   (smp_push),
    .o_full    (smp_full),
    .o_rd_data (smp_rd_data),
    .i_rd_en   (smp_pop),
    .o_empty   (smp_empty)
  );

  thr_fifo #(
    .WIDTH (`THR_LEN_W),
    .DEPTH (`THR_LEN_DEPTH)
  ) u_len_fifo (
    .i_ce_clk  (i_ce_clk),
    .i_rst_n   (i_rst_n),
    .i_wr_data (len_wr_data),
    .i_wr_en   (len_push),
    .o_full    (len_full),
    .o_rd_data (len_rd_data),
    .i_rd_en   (len_pop),
    .o_empty   (len_empty)
  );

  thr_ctrl u_ctrl (
    .i_ce_clk    (i_ce_clk),
    .i_rst_n     (i_rst_n),
    .i_clear     (i_clear),
    .i_set_stb   (i_set_stb),
    .i_set_addr  (i_set_addr),
    .i_set_data  (i_set_data),
    .i_rb_addr   (i_rb_addr),
    .o_rb_data   (o_rb_data),
    .o_threshold (threshold),
    .i_kept_stb  (kept_stb),
    .i_len_data  (len_rd_data),
    .i_len_empty (len_empty),
    .o_len_pop   (len_pop),
    // Framer pops only when a packet is known complete
    .i_smp_data  (smp_rd_data),
    .o_smp_pop   (smp_pop),
    .o_tdata     (o_tdata),
    .o_tlast     (o_tlast),
    .o_tvalid    (o_tvalid),
    .i_tready    (i_tready)
  );

endmodule
